// ==== common/dma_desc_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface dma_desc_if;
    import dma_pkg::*;

    logic       valid;
    logic       ready;
    dma_descr_t descr;

    // descriptor producer
    modport source (output valid, output descr, input ready);

    // descriptor consumer
    modport sink (input valid, input descr, output ready);

endinterface : dma_desc_if

`default_nettype wire

// ==== common/dma_pkg.sv ====
`default_nettype none

package dma_pkg;

    // memory and control address width
    localparam int unsigned AddrWidth = 32;
    // data word width on both ports
    localparam int unsigned DataWidth = 32;
    // transfer id width
    localparam int unsigned IdWidth   = 28;

    // word offsets inside one register set, taken from address bits 4:2
    typedef enum logic [2:0] {
        REG_SRC       = 3'd0,
        REG_DST       = 3'd1,
        REG_NUM_BYTES = 3'd2,
        REG_LAUNCH    = 3'd3,
        REG_DONE_ID   = 3'd4,
        REG_STATUS    = 3'd5
    } reg_offset_e;

    // copy engine states
    typedef enum logic [1:0] {
        COPY_IDLE,
        COPY_READ,
        COPY_WRITE,
        COPY_DONE
    } copy_state_e;

    // one 1D transfer
    typedef struct packed {
        logic [AddrWidth-1:0] src_addr;
        logic [AddrWidth-1:0] dst_addr;
        logic [31:0]          num_bytes;
    } dma_descr_t;

endpackage : dma_pkg

`default_nettype wire

// ==== dma_backend/dma_copy_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_copy_engine (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    dma_desc_if.sink                      desc,
    output logic                          mem_req_o,
    output logic                          mem_we_o,
    output logic [dma_pkg::AddrWidth-1:0] mem_addr_o,
    output logic [dma_pkg::DataWidth-1:0] mem_wdata_o,
    input  logic                          mem_gnt_i,
    input  logic                          mem_rvalid_i,
    input  logic [dma_pkg::DataWidth-1:0] mem_rdata_i,
    output logic                          done_o,
    output logic                          idle_o
);
    import dma_pkg::*;

    copy_state_e          state_d;
    copy_state_e          state_q;
    dma_descr_t           descr_q;
    logic [29:0]          word_idx_q;
    logic                 rd_wait_q;
    logic [DataWidth-1:0] rdata_q;
    logic [AddrWidth-1:0] word_offset;
    logic                 last_word;
    logic                 accept;

    assign desc.ready  = (state_q == COPY_IDLE);
    assign accept      = desc.valid & desc.ready;
    assign word_offset = {word_idx_q, 2'b00};
    assign last_word   = (word_idx_q + 30'd1) == descr_q.num_bytes[31:2];

    always_comb begin : proc_next_state
        state_d = state_q;
        case (state_q)
            COPY_IDLE: begin
                if (desc.valid) begin
                    // zero words skip the copy loop
                    state_d = (desc.descr.num_bytes[31:2] == '0) ? COPY_DONE : COPY_READ;
                end
            end
            COPY_READ: begin
                if (rd_wait_q && mem_rvalid_i) begin
                    state_d = COPY_WRITE;
                end
            end
            COPY_WRITE: begin
                if (mem_gnt_i) begin
                    state_d = last_word ? COPY_DONE : COPY_READ;
                end
            end
            COPY_DONE: state_d = COPY_IDLE;
            default:   state_d = COPY_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
        if (!rst_ni) begin
            state_q    <= COPY_IDLE;
            word_idx_q <= '0;
            rd_wait_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                word_idx_q <= '0;
            end else if (state_q == COPY_WRITE && mem_gnt_i) begin
                word_idx_q <= word_idx_q + 30'd1;
            end
            // read granted, waiting for its data
            if (state_q == COPY_READ && !rd_wait_q && mem_gnt_i) begin
                rd_wait_q <= 1'b1;
            end else if (mem_rvalid_i) begin
                rd_wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin : proc_payload
        if (accept) begin
            descr_q <= desc.descr;
        end
        if (state_q == COPY_READ && rd_wait_q && mem_rvalid_i) begin
            rdata_q <= mem_rdata_i;
        end
    end

    // request held until granted
    assign mem_req_o   = ((state_q == COPY_READ) & ~rd_wait_q) | (state_q == COPY_WRITE);
    assign mem_we_o    = (state_q == COPY_WRITE);
    assign mem_addr_o  = (state_q == COPY_WRITE) ? descr_q.dst_addr + word_offset
                                                 : descr_q.src_addr + word_offset;
    assign mem_wdata_o = rdata_q;

    assign done_o = (state_q == COPY_DONE);
    assign idle_o = (state_q == COPY_IDLE);

endmodule : dma_copy_engine

`default_nettype wire

// ==== hw/dma_cluster_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_cluster_frontend #(
    parameter int unsigned NumPorts = 2
) (
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    // one control bundle per requester
    input  logic [NumPorts-1:0]                         ctrl_req_i,
    input  logic [NumPorts-1:0]                         ctrl_we_i,
    input  logic [NumPorts-1:0][dma_pkg::AddrWidth-1:0] ctrl_addr_i,
    input  logic [NumPorts-1:0][dma_pkg::DataWidth-1:0] ctrl_wdata_i,
    output logic [NumPorts-1:0]                         ctrl_gnt_o,
    output logic [NumPorts-1:0]                         ctrl_rvalid_o,
    output logic [NumPorts-1:0][dma_pkg::DataWidth-1:0] ctrl_rdata_o,
    // word memory port
    output logic                                        mem_req_o,
    output logic                                        mem_we_o,
    output logic [dma_pkg::AddrWidth-1:0]               mem_addr_o,
    output logic [dma_pkg::DataWidth-1:0]               mem_wdata_o,
    input  logic                                        mem_gnt_i,
    input  logic                                        mem_rvalid_i,
    input  logic [dma_pkg::DataWidth-1:0]               mem_rdata_i,
    output logic                                        busy_o,
    output logic                                        done_event_o
);
    import dma_pkg::*;

    logic [IdWidth-1:0] next_id;
    logic [IdWidth-1:0] done_id;
    logic               issue;
    logic               engine_idle;

    dma_desc_if port_desc [NumPorts] ();
    dma_desc_if engine_desc ();

    for (genvar i = 0; i < NumPorts; i++) begin : gen_port_regs
        dma_frontend_regs i_regs (
            .clk_i         ( clk_i            ),
            .rst_ni        ( rst_ni           ),
            .ctrl_req_i    ( ctrl_req_i[i]    ),
            .ctrl_we_i     ( ctrl_we_i[i]     ),
            .ctrl_addr_i   ( ctrl_addr_i[i]   ),
            .ctrl_wdata_i  ( ctrl_wdata_i[i]  ),
            .ctrl_gnt_o    ( ctrl_gnt_o[i]    ),
            .ctrl_rvalid_o ( ctrl_rvalid_o[i] ),
            .ctrl_rdata_o  ( ctrl_rdata_o[i]  ),
            .next_id_i     ( next_id          ),
            .done_id_i     ( done_id          ),
            .busy_i        ( busy_o           ),
            .desc          ( port_desc[i]     )
        );
    end

    dma_rr_arbiter #(
        .NumPorts ( NumPorts )
    ) i_arbiter (
        .clk_i  ( clk_i       ),
        .rst_ni ( rst_ni      ),
        .req_if ( port_desc   ),
        .out_if ( engine_desc )
    );

    // one id per descriptor taken by the engine
    assign issue = engine_desc.valid & engine_desc.ready;

    dma_transfer_id_gen i_id_gen (
        .clk_i       ( clk_i        ),
        .rst_ni      ( rst_ni       ),
        .issue_i     ( issue        ),
        .retire_i    ( done_event_o ),
        .next_o      ( next_id      ),
        .completed_o ( done_id      )
    );

    dma_copy_engine i_copy_engine (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .desc         ( engine_desc  ),
        .mem_req_o    ( mem_req_o    ),
        .mem_we_o     ( mem_we_o     ),
        .mem_addr_o   ( mem_addr_o   ),
        .mem_wdata_o  ( mem_wdata_o  ),
        .mem_gnt_i    ( mem_gnt_i    ),
        .mem_rvalid_i ( mem_rvalid_i ),
        .mem_rdata_i  ( mem_rdata_i  ),
        .done_o       ( done_event_o ),
        .idle_o       ( engine_idle  )
    );

    assign busy_o = ~engine_idle;

endmodule : dma_cluster_frontend

`default_nettype wire

// ==== hw/dma_frontend_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_frontend_regs (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          ctrl_req_i,
    input  logic                          ctrl_we_i,
    input  logic [dma_pkg::AddrWidth-1:0] ctrl_addr_i,
    input  logic [dma_pkg::DataWidth-1:0] ctrl_wdata_i,
    output logic                          ctrl_gnt_o,
    output logic                          ctrl_rvalid_o,
    output logic [dma_pkg::DataWidth-1:0] ctrl_rdata_o,
    input  logic [dma_pkg::IdWidth-1:0]   next_id_i,
    input  logic [dma_pkg::IdWidth-1:0]   done_id_i,
    input  logic                          busy_i,
    dma_desc_if.source                    desc
);
    import dma_pkg::*;

    reg_offset_e          offset;
    logic                 launch_rd;
    logic [AddrWidth-1:0] src_q;
    logic [AddrWidth-1:0] dst_q;
    logic [31:0]          num_bytes_q;
    logic [DataWidth-1:0] rdata_d;
    logic [DataWidth-1:0] rdata_q;
    logic                 rvalid_q;

    assign offset = reg_offset_e'(ctrl_addr_i[4:2]);

    // a read of the launch word submits the descriptor
    assign launch_rd = ctrl_req_i & ~ctrl_we_i & (offset == REG_LAUNCH);

    assign desc.valid = launch_rd;
    assign desc.descr = '{src_addr: src_q, dst_addr: dst_q, num_bytes: num_bytes_q};

    // launch stalls until the arbiter takes the descriptor
    assign ctrl_gnt_o = ctrl_req_i & (~launch_rd | desc.ready);

    always_comb begin : proc_read_mux
        rdata_d = '0;
        case (offset)
            REG_SRC:       rdata_d = src_q;
            REG_DST:       rdata_d = dst_q;
            REG_NUM_BYTES: rdata_d = num_bytes_q;
            // id assigned in the handshake cycle
            REG_LAUNCH:    rdata_d = DataWidth'(next_id_i);
            REG_DONE_ID:   rdata_d = DataWidth'(done_id_i);
            REG_STATUS:    rdata_d = {{(DataWidth-1){1'b0}}, busy_i};
            default:       rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_descr_regs
        if (!rst_ni) begin
            src_q       <= '0;
            dst_q       <= '0;
            num_bytes_q <= '0;
        end else if (ctrl_req_i && ctrl_we_i) begin
            case (offset)
                REG_SRC:       src_q       <= ctrl_wdata_i;
                REG_DST:       dst_q       <= ctrl_wdata_i;
                REG_NUM_BYTES: num_bytes_q <= ctrl_wdata_i;
                // read-only words
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rvalid
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= ctrl_gnt_o;
        end
    end

    always_ff @(posedge clk_i) begin : proc_rdata
        if (ctrl_gnt_o && !ctrl_we_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign ctrl_rvalid_o = rvalid_q;
    assign ctrl_rdata_o  = rdata_q;

endmodule : dma_frontend_regs

`default_nettype wire

// ==== hw/dma_rr_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_rr_arbiter #(
    parameter int unsigned NumPorts = 2
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    dma_desc_if.sink   req_if [NumPorts],
    dma_desc_if.source out_if
);
    import dma_pkg::*;

    localparam int unsigned IdxWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

    logic [NumPorts-1:0] in_valid;
    dma_descr_t          in_descr [NumPorts];
    logic [IdxWidth-1:0] rr_ptr_q;
    logic [IdxWidth-1:0] lock_idx_q;
    logic [IdxWidth-1:0] sel_idx;
    logic                lock_q;
    logic                any_valid;
    logic                handshake;

    // flatten the interface array
    for (genvar i = 0; i < NumPorts; i++) begin : gen_ports
        assign in_valid[i]     = req_if[i].valid;
        assign in_descr[i]     = req_if[i].descr;
        assign req_if[i].ready = handshake & (sel_idx == IdxWidth'(i));
    end

    always_comb begin : proc_select
        int idx;
        idx       = 0;
        sel_idx   = rr_ptr_q;
        any_valid = 1'b0;
        if (lock_q) begin
            sel_idx   = lock_idx_q;
            any_valid = in_valid[lock_idx_q];
        end else begin
            // walk downwards so the port closest to the pointer wins
            for (int k = int'(NumPorts) - 1; k >= 0; k--) begin
                idx = (int'(rr_ptr_q) + k) % int'(NumPorts);
                if (in_valid[idx]) begin
                    sel_idx   = IdxWidth'(idx);
                    any_valid = 1'b1;
                end
            end
        end
    end

    assign out_if.valid = any_valid;
    assign out_if.descr = in_descr[sel_idx];
    assign handshake    = any_valid & out_if.ready;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_lock
        if (!rst_ni) begin
            rr_ptr_q   <= '0;
            lock_idx_q <= '0;
            lock_q     <= 1'b0;
        end else if (handshake) begin
            lock_q   <= 1'b0;
            rr_ptr_q <= IdxWidth'((int'(sel_idx) + 1) % int'(NumPorts));
        end else if (any_valid) begin
            // hold the choice while the back end is busy
            lock_q     <= 1'b1;
            lock_idx_q <= sel_idx;
        end
    end

endmodule : dma_rr_arbiter

`default_nettype wire

// ==== hw/dma_transfer_id_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module dma_transfer_id_gen (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        issue_i,
    input  logic                        retire_i,
    output logic [dma_pkg::IdWidth-1:0] next_o,
    output logic [dma_pkg::IdWidth-1:0] completed_o
);
    import dma_pkg::*;

    logic [IdWidth-1:0] next_q;
    logic [IdWidth-1:0] completed_q;

    // both counters wrap around
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_counters
        if (!rst_ni) begin
            next_q      <= '0;
            completed_q <= '0;
        end else begin
            if (issue_i) begin
                next_q <= next_q + IdWidth'(1);
            end
            if (retire_i) begin
                completed_q <= completed_q + IdWidth'(1);
            end
        end
    end

    assign next_o      = next_q;
    assign completed_o = completed_q;

endmodule : dma_transfer_id_gen

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DMA front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_dma_cluster_frontend -Mdir obj_dir

out=$(./obj_dir/Vtb_dma_cluster_frontend)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== verification/dma_stimulus.txt ====
# columns in hex: test port src_addr dst_addr num_bytes
# test 1 only writes the registers and reads them back
1 0 00c0ffee 0badf00d 00000ff0
1 1 13579bdf 2468ace0 0000abcd
2 0 00000000 00000200 00000020
3 0 00000040 00000240 00000010
3 1 00000080 00000280 00000018
4 1 00000100 00000300 00000000
5 0 00000120 00000320 00000040
5 1 00000160 00000360 00000020
6 0 00000180 00000380 00000080

// ==== verification/tb_dma_cluster_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dma_cluster_frontend;
    import dma_pkg::*;

    localparam int NumPorts = 2;
    localparam int MemWords = 256;
    localparam int Timeout  = 4000;

    logic                          clk_i;
    logic                          rst_ni;
    logic [NumPorts-1:0]           ctrl_req;
    logic [NumPorts-1:0]           ctrl_we;
    logic [NumPorts-1:0][31:0]     ctrl_addr;
    logic [NumPorts-1:0][31:0]     ctrl_wdata;
    logic [NumPorts-1:0]           ctrl_gnt;
    logic [NumPorts-1:0]           ctrl_rvalid;
    logic [NumPorts-1:0][31:0]     ctrl_rdata;
    logic                          mem_req;
    logic                          mem_we;
    logic [31:0]                   mem_addr;
    logic [31:0]                   mem_wdata;
    logic                          mem_gnt    = 1'b0;
    logic                          mem_rvalid = 1'b0;
    logic [31:0]                   mem_rdata  = '0;
    logic                          busy;
    logic                          done_event;

    logic [31:0] mem    [MemWords];
    logic [31:0] shadow [MemWords];
    integer      seed        = 32'h55db;
    logic        stall_mode  = 1'b0;
    int          done_count  = 0;
    int          next_id_exp = 0;
    int          done_exp    = 0;
    int          checks      = 0;
    int          errors      = 0;

    // one entry per line of the stimulus file
    int          st_test  [$];
    int          st_port  [$];
    logic [31:0] st_src   [$];
    logic [31:0] st_dst   [$];
    logic [31:0] st_bytes [$];

    dma_cluster_frontend #(
        .NumPorts ( NumPorts )
    ) DUT (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .ctrl_req_i    ( ctrl_req    ),
        .ctrl_we_i     ( ctrl_we     ),
        .ctrl_addr_i   ( ctrl_addr   ),
        .ctrl_wdata_i  ( ctrl_wdata  ),
        .ctrl_gnt_o    ( ctrl_gnt    ),
        .ctrl_rvalid_o ( ctrl_rvalid ),
        .ctrl_rdata_o  ( ctrl_rdata  ),
        .mem_req_o     ( mem_req     ),
        .mem_we_o      ( mem_we      ),
        .mem_addr_o    ( mem_addr    ),
        .mem_wdata_o   ( mem_wdata   ),
        .mem_gnt_i     ( mem_gnt     ),
        .mem_rvalid_i  ( mem_rvalid  ),
        .mem_rdata_i   ( mem_rdata   ),
        .busy_o        ( busy        ),
        .done_event_o  ( done_event  )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // word memory driven in the low phase
    initial begin : mem_model
        logic [31:0] rnd;
        logic [31:0] rd_addr;
        logic        rd_pend;
        rd_pend = 1'b0;
        rd_addr = '0;
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = $random(seed);
        end
        forever begin
            @(negedge clk_i);
            // read data one cycle after the grant
            mem_rvalid = rd_pend;
            if (rd_pend) begin
                mem_rdata = mem[rd_addr[9:2]];
            end
            rnd     = $random(seed);
            mem_gnt = mem_req & (~stall_mode | rnd[0]);
            rd_pend = mem_gnt & ~mem_we;
            rd_addr = mem_addr;
            if (mem_gnt && mem_we) begin
                mem[mem_addr[9:2]] = mem_wdata;
            end
        end
    end

    initial begin : done_monitor
        forever begin
            @(negedge clk_i);
            if (done_event) begin
                done_count++;
            end
        end
    end

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Error: %s expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_memory();
        checks++;
        for (int i = 0; i < MemWords; i++) begin
            assert (mem[i] === shadow[i]) else begin
                $display("Error: mem[%h] expected %h, got %h", i * 4, shadow[i], mem[i]);
                errors++;
            end
        end
    endtask

    // one control access that waits for gnt and then rvalid
    task automatic ctrl_access(input int p, input logic we, input reg_offset_e off,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int   cycles;
        logic granted;
        logic got;
        rdata   = '0;
        granted = 1'b0;
        got     = 1'b0;
        cycles  = 0;
        @(negedge clk_i);
        ctrl_req[p]   = 1'b1;
        ctrl_we[p]    = we;
        ctrl_addr[p]  = {27'd0, off, 2'b00};
        ctrl_wdata[p] = wdata;
        while (!granted && cycles < Timeout) begin
            #2;
            granted = ctrl_gnt[p];
            @(negedge clk_i);
            cycles++;
        end
        ctrl_req[p] = 1'b0;
        ctrl_we[p]  = 1'b0;
        if (!granted) begin
            $display("timeout: port %0d never got a grant for offset %0d", p, off);
            errors++;
        end else begin
            cycles = 0;
            while (!got && cycles < Timeout) begin
                #2;
                got = ctrl_rvalid[p];
                if (got) begin
                    rdata = ctrl_rdata[p];
                end else begin
                    @(negedge clk_i);
                    cycles++;
                end
            end
            if (!got) begin
                $display("timeout: port %0d never returned read data", p);
                errors++;
            end
        end
    endtask

    task automatic read_reg(input int p, input reg_offset_e off, output logic [31:0] rdata);
        ctrl_access(p, 1'b0, off, '0, rdata);
    endtask

    task automatic program_regs(input int p, input logic [31:0] src, input logic [31:0] dst,
                                input logic [31:0] num_bytes);
        logic [31:0] unused;
        ctrl_access(p, 1'b1, REG_SRC, src, unused);
        ctrl_access(p, 1'b1, REG_DST, dst, unused);
        ctrl_access(p, 1'b1, REG_NUM_BYTES, num_bytes, unused);
    endtask

    // reference copy word by word upwards
    task automatic model_copy(input logic [31:0] src, input logic [31:0] dst,
                              input logic [31:0] num_bytes);
        logic [7:0] s;
        logic [7:0] d;
        s = src[9:2];
        d = dst[9:2];
        for (int w = 0; w < int'(num_bytes[31:2]); w++) begin
            shadow[d] = shadow[s];
            s++;
            d++;
        end
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target && cycles < Timeout) begin
            @(negedge clk_i);
            #1;
            cycles++;
        end
        if (done_count < target) begin
            $display("timeout: done pulse number %0d never arrived", target);
            errors++;
        end
    endtask

    task automatic copy_one(input int k, input logic watch_busy);
        logic [31:0] rd;
        int          other;
        other = (st_port[k] + 1) % NumPorts;
        program_regs(st_port[k], st_src[k], st_dst[k], st_bytes[k]);
        read_reg(st_port[k], REG_LAUNCH, rd);
        check_equal("launch id", 32'(next_id_exp), rd);
        next_id_exp++;
        model_copy(st_src[k], st_dst[k], st_bytes[k]);
        if (watch_busy) begin
            read_reg(other, REG_STATUS, rd);
            check_equal("REG_STATUS", 32'd1, rd);
            check_equal("busy_o", 32'd1, {31'd0, busy});
        end
        done_exp++;
        wait_done(done_exp);
        if (watch_busy) begin
            read_reg(other, REG_STATUS, rd);
            check_equal("REG_STATUS", 32'd0, rd);
            check_equal("busy_o", 32'd0, {31'd0, busy});
        end
        check_memory();
        read_reg(st_port[k], REG_DONE_ID, rd);
        check_equal("REG_DONE_ID", 32'(done_exp), rd);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          t;
        int          p;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] b;
        string       line;
        fd = $fopen("verification/dma_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            code = $fgets(line, fd);
            while (code > 0) begin
                if (line.len() > 0 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h", t, p, s, d, b) == 5) begin
                    st_test.push_back(t);
                    st_port.push_back(p);
                    st_src.push_back(s);
                    st_dst.push_back(d);
                    st_bytes.push_back(b);
                end
                code = $fgets(line, fd);
            end
            $fclose(fd);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: FAIL with %0d errors", num, name, errors - errs_before);
        end
    endtask

    initial begin : main
        int          errs;
        int          pair [$];
        logic [31:0] rd;
        logic [31:0] id0;
        logic [31:0] id1;
        ctrl_req   = '0;
        ctrl_we    = '0;
        ctrl_addr  = '0;
        ctrl_wdata = '0;
        rst_ni     = 1'b0;
        load_stimulus();
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < MemWords; i++) begin
            shadow[i] = mem[i];
        end

        errs = errors;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 1) begin
                program_regs(st_port[k], st_src[k], st_dst[k], st_bytes[k]);
                read_reg(st_port[k], REG_SRC, rd);
                check_equal("REG_SRC", st_src[k], rd);
                read_reg(st_port[k], REG_DST, rd);
                check_equal("REG_DST", st_dst[k], rd);
                read_reg(st_port[k], REG_NUM_BYTES, rd);
                check_equal("REG_NUM_BYTES", st_bytes[k], rd);
            end
        end
        for (int p = 0; p < NumPorts; p++) begin
            read_reg(p, REG_DONE_ID, rd);
            check_equal("REG_DONE_ID", 32'd0, rd);
        end
        report_test(1, "register access", errs);

        errs = errors;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 2) copy_one(k, 1'b0);
        end
        report_test(2, "single copy", errs);

        errs = errors;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 3) pair.push_back(k);
        end
        if (pair.size() != 2) begin
            $display("test 3 needs two transfers in the stimulus file");
            errors++;
        end else begin
            program_regs(st_port[pair[0]], st_src[pair[0]], st_dst[pair[0]], st_bytes[pair[0]]);
            program_regs(st_port[pair[1]], st_src[pair[1]], st_dst[pair[1]], st_bytes[pair[1]]);
            // both launches in the same cycle
            fork
                read_reg(st_port[pair[0]], REG_LAUNCH, id0);
                read_reg(st_port[pair[1]], REG_LAUNCH, id1);
            join
            check_equal("launch id low", 32'(next_id_exp), (id0 < id1) ? id0 : id1);
            check_equal("launch id high", 32'(next_id_exp + 1), (id0 < id1) ? id1 : id0);
            next_id_exp += 2;
            model_copy(st_src[pair[0]], st_dst[pair[0]], st_bytes[pair[0]]);
            model_copy(st_src[pair[1]], st_dst[pair[1]], st_bytes[pair[1]]);
            done_exp += 2;
            wait_done(done_exp);
            check_memory();
            read_reg(0, REG_DONE_ID, rd);
            check_equal("REG_DONE_ID", 32'(done_exp), rd);
        end
        report_test(3, "concurrent launches", errs);

        errs = errors;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 4) copy_one(k, 1'b0);
        end
        report_test(4, "zero-length transfer", errs);

        errs = errors;
        stall_mode = 1'b1;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 5) copy_one(k, 1'b0);
        end
        stall_mode = 1'b0;
        report_test(5, "memory back-pressure", errs);

        errs = errors;
        for (int k = 0; k < st_test.size(); k++) begin
            if (st_test[k] == 6) copy_one(k, 1'b1);
        end
        report_test(6, "busy status", errs);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_dma_cluster_frontend

`default_nettype wire

// ==== vlog.f ====
common/dma_pkg.sv
common/dma_desc_if.sv
hw/dma_frontend_regs.sv
hw/dma_rr_arbiter.sv
hw/dma_transfer_id_gen.sv
dma_backend/dma_copy_engine.sv
hw/dma_cluster_frontend.sv
verification/tb_dma_cluster_frontend.sv
